// ==== bus_config.svh ====
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// bus geometry
`define ADDR_WIDTH   32
`define DATA_WIDTH   32
`define BE_WIDTH     (`DATA_WIDTH/8)

// 8192 words per lane, 32 KB in total
`define RAM_AW       13

// address map
`define RAM_BASE     32'h0000_0000
`define TIMER_BASE   32'h0001_0000
`define REGION_MASK  32'hFFFF_8000   // 32 KB regions

`endif

// ==== bus_pkg.sv ====
package bus_pkg;

    // access size as seen on the byte enables
    typedef enum logic [3:0] {
        SZ_BAD  = 4'b0000,   // anything not listed below
        SZ_BYTE = 4'b0001,
        SZ_HALF = 4'b0011,
        SZ_WORD = 4'b1111
    } access_size_e;

    // two-phase command handling in the peripherals
    typedef enum logic {
        ISSUE  = 1'b0,
        RETIRE = 1'b1
    } cmd_state_e;

    function automatic access_size_e size_of(input logic [3:0] be);
        case (be)
            4'b0001: return SZ_BYTE;
            4'b0011: return SZ_HALF;
            4'b1111: return SZ_WORD;
            default: return SZ_BAD;
        endcase
    endfunction

endpackage

// ==== periph_pkg.sv ====
package periph_pkg;

    // timer register word offsets, low address byte
    typedef enum logic [7:0] {
        TMR_CTRL    = 8'h00,
        TMR_COUNT   = 8'h04,
        TMR_COMPARE = 8'h08,
        TMR_STATUS  = 8'h0C
    } timer_reg_e;

    // TMR_CTRL bits
    localparam int CTRL_RUN_BIT = 0;

    // TMR_STATUS bits, write 1 to clear
    localparam int STAT_PEND_BIT = 0;

endpackage

// ==== periph_bus_if.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

interface periph_bus_if;

    // command side
    logic                   enable;     // must drop between commands
    logic                   wr_en;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`BE_WIDTH-1:0]   be;

    // response side
    logic                   ready;
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   irq;
    logic                   bus_err;    // only valid with ready

    modport host (
        output enable, wr_en, addr, wdata, be,
        input  ready, rdata, irq, bus_err
    );

    modport periph (
        input  enable, wr_en, addr, wdata, be,
        output ready, rdata, irq, bus_err
    );

endinterface

// ==== byte_lane_ram.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module byte_lane_ram
(
    input  logic               clk,
    input  logic               i_ce,
    input  logic               i_we,
    input  logic [`RAM_AW-1:0] i_addr,
    input  logic [7:0]         i_din,
    output logic [7:0]         o_dout
);

    logic [7:0] mem [0:(1<<`RAM_AW)-1];

    // single port, read data held until the next enabled read
    always_ff @(posedge clk)
    begin
        if (i_ce)
        begin
            if (i_we)
            begin
                mem[i_addr] <= i_din;
            end
            else
            begin
                o_dout <= mem[i_addr];
            end
        end
    end

endmodule

// ==== sp_bram.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module sp_bram
(
    input  logic         clk,
    input  logic         rst_n,
    periph_bus_if.periph bus
);

    logic [`BE_WIDTH-1:0]   ce;          // lane chip enables
    logic [`DATA_WIDTH-1:0] lane_din;    // write data already on its lanes
    logic [`DATA_WIDTH-1:0] lane_dout;
    logic                   ready;
    logic                   err;
    logic                   misaligned;
    bus_pkg::cmd_state_e    state;
    bus_pkg::access_size_e  size;

    assign size = bus_pkg::size_of(bus.be);

    always_comb
    begin
        case (size)
            bus_pkg::SZ_WORD: misaligned = (bus.addr[1:0] != 2'b00);
            bus_pkg::SZ_HALF: misaligned = bus.addr[0];
            default:          misaligned = 1'b0;   // bytes go anywhere
        endcase
    end

    genvar g;
    generate
        for (g = 0; g < `BE_WIDTH; g++)
        begin : g_lane
            byte_lane_ram u_lane (
                .clk    (clk),
                .i_ce   (ce[g]),
                .i_we   (bus.wr_en),
                .i_addr (bus.addr[`RAM_AW+1:2]),   // word address
                .i_din  (lane_din[8*g +: 8]),
                .o_dout (lane_dout[8*g +: 8])
            );
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ce    <= '0;
            ready <= 1'b0;
            err   <= 1'b0;
            state <= bus_pkg::ISSUE;
        end
        else if (bus.enable && !ready)
        begin
            case (state)
                bus_pkg::ISSUE:
                begin
                    if (size == bus_pkg::SZ_BAD || misaligned)
                    begin
                        err   <= 1'b1;   // answer now, lanes stay idle
                        ready <= 1'b1;
                    end
                    else if (bus.wr_en)
                    begin
                        ce    <= bus.be << bus.addr[1:0];   // only the addressed lanes
                        state <= bus_pkg::RETIRE;
                    end
                    else
                    begin
                        ce    <= '1;   // read the whole word, pick lanes later
                        state <= bus_pkg::RETIRE;
                    end
                end
                bus_pkg::RETIRE:
                begin
                    ce    <= '0;
                    ready <= 1'b1;
                end
                default: state <= bus_pkg::ISSUE;
            endcase
        end
        else if (!bus.enable)
        begin
            ready <= 1'b0;
            err   <= 1'b0;
            state <= bus_pkg::ISSUE;
        end
    end

    // replicate narrow data across the word, ce picks the lanes
    always_ff @(posedge clk)
    begin
        if (bus.enable && state == bus_pkg::ISSUE)
        begin
            case (size)
                bus_pkg::SZ_BYTE: lane_din <= {`BE_WIDTH{bus.wdata[7:0]}};
                bus_pkg::SZ_HALF: lane_din <= {(`BE_WIDTH/2){bus.wdata[15:0]}};
                default:          lane_din <= bus.wdata;
            endcase
        end
    end

    // zero-extended lane select, valid once the lanes have registered
    always_comb
    begin
        case (size)
            bus_pkg::SZ_BYTE:
                bus.rdata = {{(`DATA_WIDTH-8){1'b0}}, lane_dout[8*bus.addr[1:0] +: 8]};
            bus_pkg::SZ_HALF:
                bus.rdata = {{(`DATA_WIDTH-16){1'b0}}, lane_dout[16*bus.addr[1] +: 16]};
            default:
                bus.rdata = lane_dout;
        endcase
    end

    assign bus.ready   = ready;
    assign bus.bus_err = err;
    assign bus.irq     = 1'b0;   // memory never interrupts

endmodule

// ==== bus_timer.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_timer
(
    input  logic         clk,
    input  logic         rst_n,
    periph_bus_if.periph bus
);

    logic                   ready;
    logic                   err;
    logic                   run;
    logic                   pending;
    logic                   wr_strobe;
    logic [`DATA_WIDTH-1:0] count;
    logic [`DATA_WIDTH-1:0] compare;
    logic [`DATA_WIDTH-1:0] rd_val;
    logic [`DATA_WIDTH-1:0] rdata;
    bus_pkg::cmd_state_e    state;
    periph_pkg::timer_reg_e ofs;

    assign ofs = periph_pkg::timer_reg_e'(bus.addr[7:0]);

    // register writes land in the retire cycle
    assign wr_strobe = bus.enable && !ready && bus.wr_en && (state == bus_pkg::RETIRE);

    always_comb
    begin
        rd_val = '0;
        case (ofs)
            periph_pkg::TMR_CTRL:    rd_val[periph_pkg::CTRL_RUN_BIT] = run;
            periph_pkg::TMR_COUNT:   rd_val = count;
            periph_pkg::TMR_COMPARE: rd_val = compare;
            periph_pkg::TMR_STATUS:  rd_val[periph_pkg::STAT_PEND_BIT] = pending;
            default:                 rd_val = '0;   // hole in the map
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ready   <= 1'b0;
            err     <= 1'b0;
            state   <= bus_pkg::ISSUE;
            run     <= 1'b0;
            pending <= 1'b0;
            count   <= '0;
            compare <= '0;
        end
        else
        begin
            if (bus.enable && !ready)
            begin
                if (state == bus_pkg::ISSUE)
                begin
                    if (bus_pkg::size_of(bus.be) != bus_pkg::SZ_WORD)
                    begin
                        err   <= 1'b1;   // word access only
                        ready <= 1'b1;
                    end
                    else
                    begin
                        state <= bus_pkg::RETIRE;
                    end
                end
                else
                begin
                    ready <= 1'b1;
                end
            end
            else if (!bus.enable)
            begin
                ready <= 1'b0;
                err   <= 1'b0;
                state <= bus_pkg::ISSUE;
            end

            if (wr_strobe && ofs == periph_pkg::TMR_CTRL)
                run <= bus.wdata[periph_pkg::CTRL_RUN_BIT];
            if (wr_strobe && ofs == periph_pkg::TMR_COMPARE)
                compare <= bus.wdata;

            if (wr_strobe && ofs == periph_pkg::TMR_COUNT)
                count <= bus.wdata;
            else if (run)
                count <= count + 1'b1;

            // a fresh match wins over a clear in the same cycle
            if (run && count == compare)
                pending <= 1'b1;
            else if (wr_strobe && ofs == periph_pkg::TMR_STATUS
                     && bus.wdata[periph_pkg::STAT_PEND_BIT])
                pending <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.enable && !ready && !bus.wr_en && state == bus_pkg::RETIRE)
        begin
            rdata <= rd_val;
        end
    end

    assign bus.ready   = ready;
    assign bus.bus_err = err;
    assign bus.rdata   = rdata;
    assign bus.irq     = pending;

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_decoder
(
    input  logic         clk,
    input  logic         rst_n,
    periph_bus_if.periph host,
    periph_bus_if.host   ram,
    periph_bus_if.host   tmr
);

    logic sel_ram;
    logic sel_tmr;
    logic unm_ack;   // answer for addresses nobody owns

    assign sel_ram = (host.addr & `REGION_MASK) == `RAM_BASE;
    assign sel_tmr = (host.addr & `REGION_MASK) == `TIMER_BASE;

    // command fields go to both, enable only to the owner
    assign ram.enable = host.enable && sel_ram;
    assign ram.wr_en  = host.wr_en;
    assign ram.addr   = host.addr;
    assign ram.wdata  = host.wdata;
    assign ram.be     = host.be;

    assign tmr.enable = host.enable && sel_tmr;
    assign tmr.wr_en  = host.wr_en;
    assign tmr.addr   = host.addr;
    assign tmr.wdata  = host.wdata;
    assign tmr.be     = host.be;

    always_ff @(posedge clk)
    begin
        if (!rst_n || !host.enable)
            unm_ack <= 1'b0;
        else if (!sel_ram && !sel_tmr)
            unm_ack <= 1'b1;
    end

    always_comb
    begin
        if (sel_ram)
        begin
            host.ready   = ram.ready;
            host.rdata   = ram.rdata;
            host.bus_err = ram.bus_err;
        end
        else if (sel_tmr)
        begin
            host.ready   = tmr.ready;
            host.rdata   = tmr.rdata;
            host.bus_err = tmr.bus_err;
        end
        else
        begin
            host.ready   = unm_ack;
            host.rdata   = '0;
            host.bus_err = unm_ack;   // unmapped is always an error
        end
    end

    assign host.irq = ram.irq | tmr.irq;

endmodule

// ==== soc_bus_top.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module soc_bus_top
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_enable,
    input  logic                   i_wr_en,
    input  logic [`ADDR_WIDTH-1:0] i_addr,
    input  logic [`DATA_WIDTH-1:0] i_wdata,
    input  logic [`BE_WIDTH-1:0]   i_be,
    output logic                   o_ready,
    output logic [`DATA_WIDTH-1:0] o_rdata,
    output logic                   o_irq,
    output logic                   o_bus_err
);

    periph_bus_if host_bus ();
    periph_bus_if ram_bus ();
    periph_bus_if tmr_bus ();

    // host side comes in on plain pins
    assign host_bus.enable = i_enable;
    assign host_bus.wr_en  = i_wr_en;
    assign host_bus.addr   = i_addr;
    assign host_bus.wdata  = i_wdata;
    assign host_bus.be     = i_be;

    assign o_ready   = host_bus.ready;
    assign o_rdata   = host_bus.rdata;
    assign o_irq     = host_bus.irq;
    assign o_bus_err = host_bus.bus_err;

    bus_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .host  (host_bus.periph),
        .ram   (ram_bus.host),
        .tmr   (tmr_bus.host)
    );

    sp_bram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.periph)
    );

    bus_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tmr_bus.periph)
    );

endmodule

// ==== soc_bus_sva.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module soc_bus_sva
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 enable,
    input logic                 ready,
    input logic                 bus_err,
    input logic [`BE_WIDTH-1:0] ce
);

    a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n) bus_err |-> ready)
        else $error("bus_err raised without ready");

    // response is released one edge after the host lets go
    a_ready_clears: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(enable) |=> !ready)
        else $error("ready still high after enable dropped");

    a_lanes_idle: assert property (@(posedge clk) disable iff (!rst_n) ready |-> (ce == '0))
        else $error("lane chip enable active while ready is high");

endmodule

bind sp_bram soc_bus_sva i_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (bus.enable),
    .ready   (ready),
    .bus_err (err),
    .ce      (ce)
);

// ==== tb_soc_bus.sv ====
`timescale 1ns/1ns
`include "bus_config.svh"

module tb_soc_bus;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        chk;        // compare read data too
    } cmd_row_t;

    logic        clk;
    logic        rst_n;
    logic        i_enable;
    logic        i_wr_en;
    logic [31:0] i_addr;
    logic [31:0] i_wdata;
    logic [3:0]  i_be;
    logic        o_ready;
    logic [31:0] o_rdata;
    logic        o_irq;
    logic        o_bus_err;

    cmd_row_t    table_q[$];
    logic [7:0]  shadow [0:32767];   // byte image of the RAM
    logic [31:0] rng;

    soc_bus_top i_soc_bus_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .i_be      (i_be),
        .o_ready   (o_ready),
        .o_rdata   (o_rdata),
        .o_irq     (o_irq),
        .o_bus_err (o_bus_err)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s, got %08h expected %08h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        @(posedge clk);
        #2;
        i_enable = 1'b1;
        i_wr_en  = wr;
        i_addr   = addr;
        i_wdata  = wdata;
        i_be     = be;
        n = 0;
        while (!o_ready && n < 20)
        begin
            @(posedge clk);
            #1;   // sample between edge and next drive
            n++;
        end
        if (!o_ready)
        begin
            $display("TEST FAILED");
            $fatal(1, "no ready from bus");
        end
        rdata = o_rdata;
        err   = o_bus_err;
        #1;
        i_enable = 1'b0;
        @(posedge clk);   // enable seen low here
        #2;
    endtask

    task automatic access_expect(input cmd_row_t r, input string what);
        logic [31:0] rd;
        logic        err;
        bus_access(r.wr, r.addr, r.be, r.wdata, rd, err);
        check({31'b0, err}, {31'b0, r.exp_err}, {what, " bus_err"});
        if (r.chk)
            check(rd, r.exp_rdata, {what, " rdata"});
    endtask

    // expected result from the access rules, shadow updated on legal writes
    task automatic add_cmd(input logic wr, input logic [31:0] addr, input logic [3:0] be);
        cmd_row_t r;
        int       nbytes;
        int       i;
        r = '0;
        r.wr   = wr;
        r.addr = addr;
        r.be   = be;
        if (wr)
        begin
            rng     = xorshift(rng);
            r.wdata = rng;
        end
        case (be)
            4'b0001: nbytes = 1;
            4'b0011: nbytes = 2;
            4'b1111: nbytes = 4;
            default: nbytes = 0;
        endcase
        r.exp_err = !(addr < 32'h8000 && nbytes != 0 && (addr % nbytes) == 0);
        if (!r.exp_err)
        begin
            for (i = 0; i < nbytes; i++)
            begin
                if (wr)
                    shadow[addr[14:0] + i] = r.wdata[8*i +: 8];
                else
                    r.exp_rdata[8*i +: 8] = shadow[addr[14:0] + i];
            end
            r.chk = !wr;
        end
        table_q.push_back(r);
    endtask

    task automatic build_table;
        int i;
        for (i = 0; i < 8; i++)
            add_cmd(1'b1, 32'(4*i), 4'hF);
        add_cmd(1'b1, 32'h7FFC, 4'hF);   // last word of the RAM
        for (i = 0; i < 8; i++)
            add_cmd(1'b0, 32'(4*i), 4'hF);
        add_cmd(1'b0, 32'h7FFC, 4'hF);

        add_cmd(1'b1, 32'h20, 4'hF);
        add_cmd(1'b1, 32'h24, 4'hF);
        for (i = 0; i < 4; i++)
        begin
            add_cmd(1'b1, 32'h20 + i, 4'b0001);
            add_cmd(1'b0, 32'h20, 4'hF);
        end
        for (i = 0; i < 4; i++)
            add_cmd(1'b0, 32'h20 + i, 4'b0001);
        add_cmd(1'b1, 32'h24, 4'b0011);
        add_cmd(1'b0, 32'h24, 4'hF);
        add_cmd(1'b1, 32'h26, 4'b0011);
        add_cmd(1'b0, 32'h24, 4'hF);
        add_cmd(1'b0, 32'h24, 4'b0011);
        add_cmd(1'b0, 32'h26, 4'b0011);

        // misaligned and odd byte enables, memory must stay put
        add_cmd(1'b1, 32'h30, 4'hF);
        for (i = 1; i < 4; i++)
            add_cmd(1'b1, 32'h30 + i, 4'hF);
        add_cmd(1'b1, 32'h31, 4'b0011);
        add_cmd(1'b0, 32'h33, 4'b0011);
        add_cmd(1'b1, 32'h30, 4'b0101);
        add_cmd(1'b0, 32'h30, 4'hF);

        add_cmd(1'b0, 32'h0002_0000, 4'hF);   // nobody owns these
        add_cmd(1'b1, 32'h8000_0000, 4'hF);
        add_cmd(1'b0, 32'h0, 4'hF);
    endtask

    task automatic timer_irq_test;
        cmd_row_t r;
        int       n;
        r = '0;
        r.wr = 1'b1;
        r.be = 4'hF;
        r.addr = `TIMER_BASE + 32'(periph_pkg::TMR_COMPARE);
        r.wdata = 32'd40;
        access_expect(r, "timer compare");
        r.addr = `TIMER_BASE + 32'(periph_pkg::TMR_COUNT);
        r.wdata = 32'd0;
        access_expect(r, "timer count");
        r.addr = `TIMER_BASE + 32'(periph_pkg::TMR_CTRL);
        r.wdata = 32'd1 << periph_pkg::CTRL_RUN_BIT;
        access_expect(r, "timer ctrl");

        n = 0;
        while (!o_irq && n < 200)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!o_irq)
        begin
            $display("TEST FAILED");
            $fatal(1, "no timer interrupt");
        end

        r.wr = 1'b0;
        r.chk = 1'b1;
        r.addr = `TIMER_BASE + 32'(periph_pkg::TMR_STATUS);
        r.exp_rdata = 32'd1;
        access_expect(r, "status pending");
        r.wr = 1'b1;
        r.chk = 1'b0;
        r.wdata = 32'd1;   // write one to clear
        access_expect(r, "status clear");
        check({31'b0, o_irq}, 32'd0, "irq after clear");
        r.wr = 1'b0;
        r.chk = 1'b1;
        r.exp_rdata = 32'd0;
        access_expect(r, "status cleared");

        r.be = 4'b0011;
        r.chk = 1'b0;
        r.exp_err = 1'b1;
        access_expect(r, "timer half access");
        r.be = 4'hF;
        r.chk = 1'b1;
        r.exp_err = 1'b0;
        r.addr = `TIMER_BASE + 32'(periph_pkg::TMR_COMPARE);
        r.exp_rdata = 32'd40;
        access_expect(r, "compare after error");
    endtask

    initial
    begin
        int k;
        rst_n    = 1'b0;
        i_enable = 1'b0;
        i_wr_en  = 1'b0;
        i_addr   = '0;
        i_wdata  = '0;
        i_be     = '0;
        rng      = 32'd95;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check({29'b0, o_ready, o_bus_err, o_irq}, 32'd0, "outputs after reset");

        build_table();
        for (k = 0; k < table_q.size(); k++)
            access_expect(table_q[k], $sformatf("row %0d", k));
        timer_irq_test();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
bus_pkg.sv
periph_pkg.sv
periph_bus_if.sv
byte_lane_ram.sv
sp_bram.sv
bus_timer.sv
bus_decoder.sv
soc_bus_top.sv
soc_bus_sva.sv
tb_soc_bus.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_soc_bus \
    -o tb_soc_bus \
    && ./obj_dir/tb_soc_bus | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
exit 0
